// ==== include/aim_settings.svh ====
`ifndef AIM_SETTINGS_SVH
`define AIM_SETTINGS_SVH

// Entries in each camera FIFO
`define AIM_FIFO_DEPTH 8

// Released pairs between two buffer ticks
`define AIM_TICK_PAIRS 16

// RGB565 pixel
`define AIM_PIX_W 16

`endif

// ==== src/aim_pkg.sv ====
`include "aim_settings.svh"

package aim_pkg;

    // Two cameras on the stereo board
    localparam int N_CAM = 2;

    // Raw byte as it comes off the camera bus
    typedef logic [7:0] cam_byte_t;

    // One packed RGB565 pixel, high byte first on the wire
    typedef logic [`AIM_PIX_W-1:0] pixel_t;

endpackage : aim_pkg

// ==== src/cam_byte_packer.sv ====
`timescale 1ns/1ps

module cam_byte_packer
    import aim_pkg::*;
(
    input  logic      clk      ,
    input  logic      rst_n    ,

    input  logic      vsync    ,
    input  logic      href     ,
    input  logic      byte_en  ,
    input  cam_byte_t data     ,

    output logic      pix_valid,
    output pixel_t    pix
);

    logic      have_hi;
    cam_byte_t hi_byte;
    logic      byte_ok;

    // Byte is only taken inside an active line
    assign byte_ok = byte_en && href;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_hi   <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (vsync) begin
                // Frame boundary drops any half pixel
                have_hi <= 1'b0;
            end else if (!href) begin
                have_hi <= 1'b0;
            end else if (byte_ok) begin
                if (have_hi) begin
                    have_hi   <= 1'b0;
                    pix_valid <= 1'b1;
                end else begin
                    have_hi <= 1'b1;
                end
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (byte_ok && !vsync) begin
            if (have_hi) begin
                pix <= {hi_byte, data};
            end else begin
                hi_byte <= data;
            end
        end
    end

    // Two bytes per pixel, so strobes can never be back to back
    a_no_double_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        pix_valid |=> !pix_valid
    );

endmodule : cam_byte_packer

// ==== src/pixel_fifo.sv ====
`timescale 1ns/1ps

`include "aim_settings.svh"

module pixel_fifo
    import aim_pkg::*;
#(
    parameter int DEPTH = `AIM_FIFO_DEPTH
) (
    input  logic   clk     ,
    input  logic   rst_n   ,

    input  logic   wr      ,
    input  pixel_t wdata   ,

    input  logic   rd      ,
    output pixel_t rdata   ,

    output logic   empty   ,
    output logic   overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    pixel_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_FULL);
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            // Sticky until reset, the pixel itself is lost
            if (wr && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd |-> !empty
    );

endmodule : pixel_fifo

// ==== src/pixel_combine.sv ====
`timescale 1ns/1ps

module pixel_combine
    import aim_pkg::*;
(
    input  logic                 clk       ,
    input  logic                 rst_n     ,

    input  logic   [N_CAM-1:0]   pix_valid ,
    input  pixel_t [N_CAM-1:0]   pix       ,

    output logic                 pair_valid,
    output pixel_t               pixel_1   ,
    output pixel_t               pixel_2   ,

    output logic   [N_CAM-1:0]   overflow
);

    logic   [N_CAM-1:0] fifo_empty;
    logic   [N_CAM-1:0] fifo_rd;
    pixel_t [N_CAM-1:0] fifo_rdata;
    logic               both_ready;

    // Pop only when every camera has a pixel waiting
    assign both_ready = ~|fifo_empty;

    for (genvar i = 0; i < N_CAM; i++) begin : g_fifo
        assign fifo_rd[i] = both_ready;

        pixel_fifo u_fifo (
            .clk     (clk          ),
            .rst_n   (rst_n        ),
            .wr      (pix_valid[i] ),
            .wdata   (pix[i]       ),
            .rd      (fifo_rd[i]   ),
            .rdata   (fifo_rdata[i]),
            .empty   (fifo_empty[i]),
            .overflow(overflow[i]  )
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= both_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (both_ready) begin
            pixel_1 <= fifo_rdata[0];
            pixel_2 <= fifo_rdata[1];
        end
    end

endmodule : pixel_combine

// ==== src/frame_tick.sv ====
`timescale 1ns/1ps

`include "aim_settings.svh"

module frame_tick (
    input  logic clk       ,
    input  logic rst_n     ,
    input  logic pair_valid,
    output logic tick
);

    localparam int CNT_W = ($clog2(`AIM_TICK_PAIRS) > 0) ? $clog2(`AIM_TICK_PAIRS) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`AIM_TICK_PAIRS - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (pair_valid) begin
                if (cnt == CNT_LAST) begin
                    // Wrap and mark one buffer period
                    cnt  <= '0;
                    tick <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule : frame_tick

// ==== src/aim_top.sv ====
`timescale 1ns/1ps

module aim_top
    import aim_pkg::*;
(
    input  logic                   clk        ,
    input  logic                   rst_n      ,

    // Camera i on bit / element i
    input  logic      [N_CAM-1:0]  cam_vsync  ,
    input  logic      [N_CAM-1:0]  cam_href   ,
    input  logic      [N_CAM-1:0]  cam_byte_en,
    input  cam_byte_t [N_CAM-1:0]  cam_data   ,

    output logic                   pair_valid ,
    output pixel_t                 pixel_1    ,
    output pixel_t                 pixel_2    ,
    output logic      [N_CAM-1:0]  overflow   ,

    output logic                   tick
);

    logic   [N_CAM-1:0] pix_valid;
    pixel_t [N_CAM-1:0] pix;

    for (genvar i = 0; i < N_CAM; i++) begin : g_cam
        cam_byte_packer u_packer (
            .clk      (clk           ),
            .rst_n    (rst_n         ),
            .vsync    (cam_vsync[i]  ),
            .href     (cam_href[i]   ),
            .byte_en  (cam_byte_en[i]),
            .data     (cam_data[i]   ),
            .pix_valid(pix_valid[i]  ),
            .pix      (pix[i]        )
        );
    end

    // Stereo alignment
    pixel_combine u_pixel_combine (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .pix_valid (pix_valid ),
        .pix       (pix       ),
        .pair_valid(pair_valid),
        .pixel_1   (pixel_1   ),
        .pixel_2   (pixel_2   ),
        .overflow  (overflow  )
    );

    frame_tick u_frame_tick (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .pair_valid(pair_valid),
        .tick      (tick      )
    );

endmodule : aim_top

// ==== tests/aim_tb.sv ====
`timescale 1ns/1ps

`include "aim_settings.svh"

module aim_tb
    import aim_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic      [N_CAM-1:0] cam_vsync;
    logic      [N_CAM-1:0] cam_href;
    logic      [N_CAM-1:0] cam_byte_en;
    cam_byte_t [N_CAM-1:0] cam_data;
    logic                  pair_valid;
    pixel_t                pixel_1;
    pixel_t                pixel_2;
    logic      [N_CAM-1:0] overflow;
    logic                  tick;

    string       rows[$];
    logic [31:0] exp_q[$];
    int          lat_q[$];

    int          cycles;
    int          cycle_limit;
    int          errors;
    int          pairs_seen;
    int          pairs_expected;
    int          ticks_seen;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;
    logic [N_CAM-1:0] ov_seen;
    logic [N_CAM-1:0] last_href;
    bit          trace_ok;

    aim_top dut0 (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .cam_vsync  (cam_vsync  ),
        .cam_href   (cam_href   ),
        .cam_byte_en(cam_byte_en),
        .cam_data   (cam_data   ),
        .pair_valid (pair_valid ),
        .pixel_1    (pixel_1    ),
        .pixel_2    (pixel_2    ),
        .overflow   (overflow   ),
        .tick       (tick       )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns %s: expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_cycle(input logic [N_CAM-1:0] vs, input logic [N_CAM-1:0] hr,
                               input logic [N_CAM-1:0] en, input cam_byte_t d0,
                               input cam_byte_t d1);
        @(posedge clk);
        cam_vsync   <= vs;
        cam_href    <= hr;
        cam_byte_en <= en;
        cam_data[0] <= d0;
        cam_data[1] <= d1;
    endtask

    task automatic check_outputs_low();
        check("pair_valid", 32'h0, 32'(pair_valid));
        check("tick", 32'h0, 32'(tick));
        check("overflow", 32'h0, 32'(overflow));
    endtask

    task automatic reset_dut();
        int i;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            check_outputs_low();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs_low();
    endtask

    // Data steps by one on every cycle in which that camera's byte_en is set
    task automatic run_bytes(input int n, input int lat, input logic [N_CAM-1:0] vs,
                             input logic [N_CAM-1:0] hr, input logic [N_CAM-1:0] en,
                             input cam_byte_t d0, input cam_byte_t d1);
        cam_byte_t b0;
        cam_byte_t b1;
        int        j;
        b0 = d0;
        b1 = d1;
        for (j = 0; j < n; j++) begin
            drive_cycle(vs, hr, en, b0, b1);
            if (lat > 0 && j % 2 == 1) begin
                lat_q.push_back(cycles + 1 + lat);
            end
            if (en[0]) begin
                b0 = b0 + 8'd1;
            end
            if (en[1]) begin
                b1 = b1 + 8'd1;
            end
        end
        last_href = hr;
    endtask

    task automatic idle_gap(input int max_gap);
        int k;
        k = int'($urandom % 32'(max_gap + 1));
        repeat (k) drive_cycle('0, last_href, '0, '0, '0);
    endtask

    task automatic end_test(input int t, input int exp_ov, input int exp_ticks);
        drive_cycle('0, '0, '0, '0, '0);
        last_href = '0;
        while (exp_q.size() != 0) @(posedge clk);
        // Room for a stray pair and the tick behind it
        repeat (4) @(posedge clk);
        check("overflow", 32'(exp_ov), 32'(ov_seen));
        check("tick count", 32'(exp_ticks), 32'(ticks_seen));
        check("tick count vs pairs", 32'(pairs_expected / `AIM_TICK_PAIRS), 32'(ticks_seen));
        if (lat_q.size() != 0) begin
            $display("Test %0d: %0d timed pairs never arrived", t, lat_q.size());
            errors++;
            lat_q.delete();
        end
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d done, no errors", t);
        end else begin
            tests_failed++;
            $display("Test %0d done with %0d error(s)", t, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic load_trace(output bit ok);
        int    fd;
        string line;
        byte   tag;
        fd = $fopen("tests/aim_trace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 0) begin
                    tag = line.getc(0);
                    if (tag == "S" || tag == "G" || tag == "P" || tag == "E") begin
                        rows.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end else begin
            $display("Cannot open trace file tests/aim_trace.txt");
        end
    endtask

    task automatic process_row(input string line);
        byte         tag;
        string       rest;
        int          got;
        int          t;
        int          n;
        int          lat;
        int          exp_ov;
        int          exp_ticks;
        logic        v0;
        logic        h0;
        logic        e0;
        logic        v1;
        logic        h1;
        logic        e1;
        cam_byte_t   d0;
        cam_byte_t   d1;
        pixel_t      p1;
        pixel_t      p2;
        tag  = line.getc(0);
        rest = line.substr(1, line.len() - 1);
        got  = 0;
        case (tag)
            "S": begin
                got = $sscanf(rest, "%d %d %d %d %d %d %h %d %d %d %h",
                              t, n, lat, v0, h0, e0, d0, v1, h1, e1, d1);
                if (got == 11) begin
                    run_bytes(n, lat, {v1, v0}, {h1, h0}, {e1, e0}, d0, d1);
                end
            end
            "G": begin
                got = $sscanf(rest, "%d %d", t, n);
                if (got == 2) begin
                    idle_gap(n);
                end
            end
            "P": begin
                got = $sscanf(rest, "%d %h %h", t, p1, p2);
                if (got == 3) begin
                    exp_q.push_back({p1, p2});
                    pairs_expected++;
                end
            end
            default: begin
                got = $sscanf(rest, "%d %h %d", t, exp_ov, exp_ticks);
                if (got == 3) begin
                    end_test(t, exp_ov, exp_ticks);
                end
            end
        endcase
        if ((tag == "S" && got != 11) || (tag == "G" && got != 2) ||
            ((tag == "P" || tag == "E") && got != 3)) begin
            $display("Trace row not understood: %s", line);
            errors++;
        end
    endtask

    // Each test ends at its E row
    task automatic run_trace();
        int first;
        int r;
        int k;
        first = 0;
        for (r = 0; r < rows.size(); r++) begin
            if (rows[r].getc(0) == "E") begin
                // Expected pairs must be queued before the stimulus releases them
                for (k = first; k <= r; k++) begin
                    if (rows[k].getc(0) == "P") begin
                        process_row(rows[k]);
                    end
                end
                for (k = first; k <= r; k++) begin
                    if (rows[k].getc(0) != "P") begin
                        process_row(rows[k]);
                    end
                end
                first = r + 1;
            end
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clk) begin : monitor
        logic [31:0] exp_pair;
        int          due;
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end else begin
            ov_seen = overflow;
            if (tick) begin
                ticks_seen++;
            end
            if (pair_valid) begin
                pairs_seen++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected pair %h %h at %0d ns with nothing left to match",
                             pixel_1, pixel_2, $time);
                    errors++;
                end else begin
                    exp_pair = exp_q.pop_front();
                    check("pixel_1", 32'(exp_pair[31:16]), 32'(pixel_1));
                    check("pixel_2", 32'(exp_pair[15:0]), 32'(pixel_2));
                end
                if (lat_q.size() != 0) begin
                    due = lat_q.pop_front();
                    check("pair_valid cycle", 32'(due), 32'(cycles));
                end
            end
        end
    end

    initial begin
        rst_n             = 1'b0;
        cam_vsync         = '0;
        cam_href          = '0;
        cam_byte_en       = '0;
        cam_data          = '0;
        last_href         = '0;
        ov_seen           = '0;
        cycles            = 0;
        errors            = 0;
        pairs_seen        = 0;
        pairs_expected    = 0;
        ticks_seen        = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        cycle_limit       = 200;
        void'($urandom(62));
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("Regression failed");
            $finish;
        end else begin
            cycle_limit = 2 * rows.size() + 200;
            reset_dut();
            run_trace();
            $display("Tests run %0d, failed %0d, pairs %0d, ticks %0d, errors %0d",
                     tests_run, tests_failed, pairs_seen, ticks_seen, errors);
            if (errors == 0 && tests_failed == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule : aim_tb

// ==== tests/aim_trace.txt ====
# Columns: S test cycles latency vs0 hr0 en0 data0 vs1 hr1 en1 data1 (data in hex)
#   data steps by one per counted byte, latency > 0 times a pair after every 2nd cycle
# G test max_gap, P test pixel_1 pixel_2, E test overflow_bits total_ticks
# Test 1, reset
E 1 0 0
# Test 2, lockstep assembly and pairing
S 2 1 0 1 0 0 00 1 0 0 00
S 2 8 3 0 1 1 a0 0 1 1 40
P 2 a0a1 4041
P 2 a2a3 4243
P 2 a4a5 4445
P 2 a6a7 4647
E 2 0 0
# Test 3, camera 0 seven pixels ahead
S 3 6 0 0 1 1 10 0 1 0 00
G 3 3
S 3 8 0 0 1 1 16 0 1 0 00
G 3 3
S 3 6 0 0 1 0 00 0 1 1 20
G 3 3
S 3 8 0 0 1 0 00 0 1 1 26
P 3 1011 2021
P 3 1213 2223
P 3 1415 2425
P 3 1617 2627
P 3 1819 2829
P 3 1a1b 2a2b
P 3 1c1d 2c2d
E 3 0 0
# Test 4, half pixels dropped by href low and by vsync
S 4 3 0 0 1 1 50 0 1 1 60
S 4 1 0 0 0 0 00 1 1 0 00
S 4 2 0 0 1 1 70 0 1 1 80
P 4 5051 6061
P 4 7071 8081
E 4 0 0
# Test 5, camera 0 overruns its FIFO by one pixel
S 5 18 0 0 1 1 00 0 1 0 00
G 5 2
S 5 16 0 0 1 0 00 0 1 1 30
S 5 2 0 0 1 1 e0 0 1 1 f0
P 5 0001 3031
P 5 0203 3233
P 5 0405 3435
P 5 0607 3637
P 5 0809 3839
P 5 0a0b 3a3b
P 5 0c0d 3c3d
P 5 0e0f 3e3f
P 5 e0e1 f0f1
E 5 1 1
# Test 6, tick total over all pairs
E 6 1 1

// ==== all.f ====
+incdir+include
src/aim_pkg.sv
src/cam_byte_packer.sv
src/pixel_fifo.sv
src/pixel_combine.sv
src/frame_tick.sv
src/aim_top.sv
tests/aim_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the aim_tb simulation with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -j 0 --top-module aim_tb -f all.f -o aim_sim \
    > build.log 2>&1 \
    && ./obj_dir/aim_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
